//--- source/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Reorder buffer sizing
`define ROB_DEPTH 16
`define ROB_TAG_BITS $clog2(`ROB_DEPTH)

// Execution lanes
`define NUM_LANES 3
`define LANE_ID_BITS $clog2(`NUM_LANES)
`define LANE_QUEUE_DEPTH 2              // Queue slots, also credits per lane

// Execute cycles for a multiply
`define MUL_LATENCY 4

// Data and pc width
`define XLEN 32

`endif

//--- source/rob_pkg.sv
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    typedef logic [`XLEN-1:0] xlen_t;               // Data word
    typedef logic [`XLEN-1:0] pc_t;                 // Instruction address
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;    // ROB entry index
    typedef logic [4:0] reg_idx_t;                  // Destination register
    typedef logic [`LANE_ID_BITS-1:0] lane_id_t;    // Lane number

    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_SUB     = 3'd1,
        OP_XOR     = 3'd2,
        OP_MUL     = 3'd3,
        OP_ILLEGAL = 3'd4
    } opcode_e;

    typedef enum logic {
        LANE_IDLE,
        LANE_BUSY
    } lane_state_e;

endpackage

`default_nettype wire

//--- source/op_dispatcher.sv
`default_nettype none

`include "rob_config.svh"

module op_dispatcher (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        in_valid,
    input  rob_pkg::pc_t                in_pc,
    input  rob_pkg::opcode_e            in_op,
    input  rob_pkg::reg_idx_t           in_dest,
    input  rob_pkg::xlen_t              in_a,
    input  rob_pkg::xlen_t              in_b,
    output logic                        in_ready,
    input  logic                        rob_full,
    input  rob_pkg::rob_tag_t           alloc_tag,
    output logic                        alloc,
    output rob_pkg::pc_t                alloc_pc,
    output rob_pkg::reg_idx_t           alloc_dest,
    output logic [`NUM_LANES-1:0]       issue_valid,
    output rob_pkg::rob_tag_t           issue_tag,
    output rob_pkg::opcode_e            issue_op,
    output rob_pkg::xlen_t              issue_a,
    output rob_pkg::xlen_t              issue_b,
    input  logic [`NUM_LANES-1:0]       credit_return
);

    localparam int CNT_W = $clog2(`LANE_QUEUE_DEPTH + 1);

    logic [CNT_W-1:0]       credits [`NUM_LANES];
    logic [`NUM_LANES-1:0]  has_credit;
    rob_pkg::lane_id_t      rr_ptr;                 // Lane searched first
    rob_pkg::lane_id_t      sel_lane;
    logic                   accept;

    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            has_credit[l] = (credits[l] != '0);
        end
    end

    // Round-robin pick of the first lane with a credit
    always_comb begin
        int cand;
        sel_lane = rr_ptr;
        for (int k = `NUM_LANES - 1; k >= 0; k--) begin
            cand = int'(rr_ptr) + k;
            if (cand >= `NUM_LANES) cand = cand - `NUM_LANES;
            if (has_credit[cand]) sel_lane = rob_pkg::lane_id_t'(cand);
        end
    end

    assign in_ready = !rob_full && (|has_credit) && !flush;
    assign accept   = in_valid && in_ready;

    assign alloc      = accept;                     // Tag taken on this edge
    assign alloc_pc   = in_pc;
    assign alloc_dest = in_dest;

    assign issue_valid = accept ? (`NUM_LANES'(1) << sel_lane) : '0;
    assign issue_tag   = alloc_tag;
    assign issue_op    = in_op;
    assign issue_a     = in_a;
    assign issue_b     = in_b;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                credits[l] <= CNT_W'(`LANE_QUEUE_DEPTH);    // Lanes empty again
            end
        end else begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                case ({issue_valid[l], credit_return[l]})
                    2'b10:   credits[l] <= credits[l] - 1'b1;
                    2'b01:   credits[l] <= credits[l] + 1'b1;
                    default: credits[l] <= credits[l];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (accept) begin
            rr_ptr <= (int'(sel_lane) == `NUM_LANES - 1) ? '0 : sel_lane + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_lane.sv
`default_nettype none

`include "rob_config.svh"

module exec_lane (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                issue_valid,
    input  rob_pkg::rob_tag_t   issue_tag,
    input  rob_pkg::opcode_e    issue_op,
    input  rob_pkg::xlen_t      issue_a,
    input  rob_pkg::xlen_t      issue_b,
    output logic                credit_return,
    output logic                wb_valid,
    output rob_pkg::rob_tag_t   wb_tag,
    output rob_pkg::xlen_t      wb_value,
    output logic                wb_exc
);

    localparam int DEPTH = `LANE_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int LAT_W = $clog2(`MUL_LATENCY + 1);

    rob_pkg::rob_tag_t      q_tag [DEPTH];
    rob_pkg::opcode_e       q_op  [DEPTH];
    rob_pkg::xlen_t         q_a   [DEPTH];
    rob_pkg::xlen_t         q_b   [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    rob_pkg::lane_state_e   state;
    logic [LAT_W-1:0]       cyc_left;               // Execute cycles after this one
    logic                   start;
    rob_pkg::xlen_t         start_res;
    logic                   start_exc;
    logic [LAT_W-1:0]       start_lat;
    rob_pkg::rob_tag_t      cur_tag;
    rob_pkg::xlen_t         cur_value;
    logic                   cur_exc;

    assign start         = (state == rob_pkg::LANE_IDLE) && (count != '0);
    assign credit_return = start;                   // Op leaves the queue

    // Result of the op at the queue head
    always_comb begin
        start_res = '0;
        start_exc = 1'b0;
        start_lat = '0;
        case (q_op[rd_ptr])
            rob_pkg::OP_ADD: start_res = q_a[rd_ptr] + q_b[rd_ptr];
            rob_pkg::OP_SUB: start_res = q_a[rd_ptr] - q_b[rd_ptr];
            rob_pkg::OP_XOR: start_res = q_a[rd_ptr] ^ q_b[rd_ptr];
            rob_pkg::OP_MUL: begin
                start_res = q_a[rd_ptr] * q_b[rd_ptr];      // Low XLEN bits kept
                start_lat = LAT_W'(`MUL_LATENCY - 1);
            end
            default: start_exc = 1'b1;              // Illegal, value stays zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            q_tag[wr_ptr] <= issue_tag;
            q_op[wr_ptr]  <= issue_op;
            q_a[wr_ptr]   <= issue_a;
            q_b[wr_ptr]   <= issue_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (start) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(issue_valid) - CNT_W'(start);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state    <= rob_pkg::LANE_IDLE;
            cyc_left <= '0;
        end else begin
            case (state)
                rob_pkg::LANE_IDLE: begin
                    if (start) begin
                        state    <= rob_pkg::LANE_BUSY;
                        cyc_left <= start_lat;
                    end
                end
                rob_pkg::LANE_BUSY: begin
                    if (cyc_left == '0) state <= rob_pkg::LANE_IDLE;
                    else cyc_left <= cyc_left - 1'b1;
                end
                default: state <= rob_pkg::LANE_IDLE;
            endcase
        end
    end

    // Result held until the counter runs out
    always_ff @(posedge clk) begin
        if (start) begin
            cur_tag   <= q_tag[rd_ptr];
            cur_value <= start_res;
            cur_exc   <= start_exc;
        end
    end

    assign wb_valid = (state == rob_pkg::LANE_BUSY) && (cyc_left == '0);
    assign wb_tag   = cur_tag;
    assign wb_value = cur_value;
    assign wb_exc   = cur_exc;

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`default_nettype none

`include "rob_config.svh"

module reorder_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,
    input  rob_pkg::pc_t            alloc_pc,
    input  rob_pkg::reg_idx_t       alloc_dest,
    output rob_pkg::rob_tag_t       alloc_tag,
    output logic                    rob_full,
    input  logic [`NUM_LANES-1:0]   wb_valid,
    input  rob_pkg::rob_tag_t       wb_tag [`NUM_LANES],
    input  rob_pkg::xlen_t          wb_value [`NUM_LANES],
    input  logic [`NUM_LANES-1:0]   wb_exc,
    output logic                    commit_valid,
    output rob_pkg::pc_t            commit_pc,
    output rob_pkg::reg_idx_t       commit_dest,
    output rob_pkg::xlen_t          commit_value,
    output logic                    exception_valid,
    output rob_pkg::pc_t            exception_pc,
    output logic                    flush
);

    localparam int TB = `ROB_TAG_BITS;

    logic [TB:0]                head_ptr;           // Extra bit tells full from empty
    logic [TB:0]                tail_ptr;
    rob_pkg::rob_tag_t          head_idx;
    rob_pkg::rob_tag_t          tail_idx;

    logic [`ROB_DEPTH-1:0]      valid_q;
    logic [`ROB_DEPTH-1:0]      done_q;
    logic [`ROB_DEPTH-1:0]      exc_q;
    rob_pkg::pc_t               pc_mem    [`ROB_DEPTH];
    rob_pkg::reg_idx_t          dest_mem  [`ROB_DEPTH];
    rob_pkg::xlen_t             value_mem [`ROB_DEPTH];

    logic                       head_ready;
    logic                       retire;
    logic                       raise;

    assign head_idx = head_ptr[TB-1:0];
    assign tail_idx = tail_ptr[TB-1:0];

    assign alloc_tag = tail_idx;
    assign rob_full  = (head_ptr[TB] != tail_ptr[TB]) && (head_idx == tail_idx);

    // Head decision, held off while a flush is in progress
    assign head_ready = valid_q[head_idx] && done_q[head_idx] && !exception_valid;
    assign retire     = head_ready && !exc_q[head_idx];
    assign raise      = head_ready && exc_q[head_idx];

    assign flush = exception_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            valid_q  <= '0;
            done_q   <= '0;
            exc_q    <= '0;
        end else begin
            if (alloc) begin
                valid_q[tail_idx] <= 1'b1;
                done_q[tail_idx]  <= 1'b0;
                exc_q[tail_idx]   <= 1'b0;
                tail_ptr          <= tail_ptr + 1'b1;
            end
            // Any lane may complete any entry
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (wb_valid[l] && valid_q[wb_tag[l]]) begin
                    done_q[wb_tag[l]] <= 1'b1;
                    exc_q[wb_tag[l]]  <= wb_exc[l];
                end
            end
            if (retire) begin
                valid_q[head_idx] <= 1'b0;
                head_ptr          <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pc_mem[tail_idx]   <= alloc_pc;
            dest_mem[tail_idx] <= alloc_dest;
        end
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (wb_valid[l]) begin
                value_mem[wb_tag[l]] <= wb_value[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid    <= 1'b0;
            exception_valid <= 1'b0;
        end else begin
            commit_valid    <= retire;
            exception_valid <= raise;       // Single pulse, head stays put
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_pc    <= pc_mem[head_idx];
            commit_dest  <= dest_mem[head_idx];
            commit_value <= value_mem[head_idx];
        end
        if (raise) begin
            exception_pc <= pc_mem[head_idx];
        end
    end

endmodule

`default_nettype wire

//--- source/ooo_backend.sv
`default_nettype none

`include "rob_config.svh"

module ooo_backend (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  rob_pkg::pc_t        in_pc,
    input  rob_pkg::opcode_e    in_op,
    input  rob_pkg::reg_idx_t   in_dest,
    input  rob_pkg::xlen_t      in_a,
    input  rob_pkg::xlen_t      in_b,
    output logic                in_ready,
    output logic                commit_valid,
    output rob_pkg::pc_t        commit_pc,
    output rob_pkg::reg_idx_t   commit_dest,
    output rob_pkg::xlen_t      commit_value,
    output logic                exception_valid,
    output rob_pkg::pc_t        exception_pc
);

    logic                       flush;
    logic                       alloc;
    rob_pkg::pc_t               alloc_pc;
    rob_pkg::reg_idx_t          alloc_dest;
    rob_pkg::rob_tag_t          alloc_tag;
    logic                       rob_full;

    logic [`NUM_LANES-1:0]      issue_valid;
    rob_pkg::rob_tag_t          issue_tag;
    rob_pkg::opcode_e           issue_op;
    rob_pkg::xlen_t             issue_a;
    rob_pkg::xlen_t             issue_b;
    logic [`NUM_LANES-1:0]      credit_return;

    logic [`NUM_LANES-1:0]      wb_valid;
    rob_pkg::rob_tag_t          wb_tag   [`NUM_LANES];
    rob_pkg::xlen_t             wb_value [`NUM_LANES];
    logic [`NUM_LANES-1:0]      wb_exc;

    op_dispatcher u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_op         (in_op),
        .in_dest       (in_dest),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_ready      (in_ready),
        .rob_full      (rob_full),
        .alloc_tag     (alloc_tag),
        .alloc         (alloc),
        .alloc_pc      (alloc_pc),
        .alloc_dest    (alloc_dest),
        .issue_valid   (issue_valid),
        .issue_tag     (issue_tag),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .credit_return (credit_return)
    );

    // Shared issue bus, one valid per lane
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk           (clk),
            .rst           (rst),
            .flush         (flush),
            .issue_valid   (issue_valid[i]),
            .issue_tag     (issue_tag),
            .issue_op      (issue_op),
            .issue_a       (issue_a),
            .issue_b       (issue_b),
            .credit_return (credit_return[i]),
            .wb_valid      (wb_valid[i]),
            .wb_tag        (wb_tag[i]),
            .wb_value      (wb_value[i]),
            .wb_exc        (wb_exc[i])
        );
    end

    reorder_buffer u_rob (
        .clk             (clk),
        .rst             (rst),
        .alloc           (alloc),
        .alloc_pc        (alloc_pc),
        .alloc_dest      (alloc_dest),
        .alloc_tag       (alloc_tag),
        .rob_full        (rob_full),
        .wb_valid        (wb_valid),
        .wb_tag          (wb_tag),
        .wb_value        (wb_value),
        .wb_exc          (wb_exc),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_dest     (commit_dest),
        .commit_value    (commit_value),
        .exception_valid (exception_valid),
        .exception_pc    (exception_pc),
        .flush           (flush)
    );

endmodule

`default_nettype wire

//--- tb/ooo_backend_tb.sv
`default_nettype none

module ooo_backend_tb;

    localparam int WAIT_LIMIT  = 200;       // Cycles per accept wait
    localparam int DRAIN_LIMIT = 500;

    logic               clk;
    logic               rst;
    logic               in_valid;
    rob_pkg::pc_t       in_pc;
    rob_pkg::opcode_e   in_op;
    rob_pkg::reg_idx_t  in_dest;
    rob_pkg::xlen_t     in_a;
    rob_pkg::xlen_t     in_b;
    logic               in_ready;
    logic               commit_valid;
    rob_pkg::pc_t       commit_pc;
    rob_pkg::reg_idx_t  commit_dest;
    rob_pkg::xlen_t     commit_value;
    logic               exception_valid;
    rob_pkg::pc_t       exception_pc;

    integer             seed = 32'h327fbbc0;
    rob_pkg::pc_t       next_pc = 32'h0000_1000;

    // Expected commits in program order
    rob_pkg::pc_t       exp_pc   [$];
    rob_pkg::reg_idx_t  exp_dest [$];
    rob_pkg::xlen_t     exp_val  [$];
    logic               exp_ill  [$];

    int mismatches   = 0;
    int other_errors = 0;
    int timeouts     = 0;
    int accepts      = 0;
    int commits      = 0;
    int flushed      = 0;
    int exceptions   = 0;
    logic seen_rst   = 1'b0;
    logic rst_prev   = 1'b0;
    logic saw_stall  = 1'b0;

    ooo_backend dut (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_pc           (in_pc),
        .in_op           (in_op),
        .in_dest         (in_dest),
        .in_a            (in_a),
        .in_b            (in_b),
        .in_ready        (in_ready),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_dest     (commit_dest),
        .commit_value    (commit_value),
        .exception_valid (exception_valid),
        .exception_pc    (exception_pc)
    );

    always #5 clk = ~clk;

    function automatic rob_pkg::xlen_t expected_result(input rob_pkg::opcode_e op,
                                                       input rob_pkg::xlen_t a,
                                                       input rob_pkg::xlen_t b);
        logic [63:0] prod;
        prod = 64'(a) * 64'(b);
        case (op)
            rob_pkg::OP_ADD: return a + b;
            rob_pkg::OP_SUB: return a - b;
            rob_pkg::OP_XOR: return a ^ b;
            rob_pkg::OP_MUL: return rob_pkg::xlen_t'(prod);     // Low half of product
            default:         return '0;
        endcase
    endfunction

    // Monitor on pre-edge values of the DUT ports
    always @(posedge clk) begin
        if (rst) begin
            if (seen_rst) begin
                assert (!commit_valid && !exception_valid) else begin
                    $display("commit or exception output active during reset");
                    other_errors++;
                end
            end
            seen_rst = 1'b1;
            rst_prev = 1'b1;
        end else begin
            if (rst_prev) begin
                assert (!commit_valid && !exception_valid) else begin
                    $display("commit or exception output active right after reset");
                    other_errors++;
                end
            end
            rst_prev = 1'b0;
            if (commit_valid) begin
                commits++;
                if (exp_pc.size() == 0) begin
                    $display("commit seen with no instruction pending");
                    other_errors++;
                end else begin
                    assert (!exp_ill[0]) else begin
                        $display("illegal instruction committed instead of trapping");
                        other_errors++;
                    end
                    assert (commit_pc == exp_pc[0]) else begin
                        $display("mismatch commit_pc expected %h actual %h",
                                 exp_pc[0], commit_pc);
                        mismatches++;
                    end
                    assert (commit_dest == exp_dest[0]) else begin
                        $display("mismatch commit_dest expected %h actual %h",
                                 exp_dest[0], commit_dest);
                        mismatches++;
                    end
                    assert (commit_value == exp_val[0]) else begin
                        $display("mismatch commit_value expected %h actual %h",
                                 exp_val[0], commit_value);
                        mismatches++;
                    end
                    void'(exp_pc.pop_front());
                    void'(exp_dest.pop_front());
                    void'(exp_val.pop_front());
                    void'(exp_ill.pop_front());
                end
            end
            if (exception_valid) begin
                assert (!commit_valid) else begin
                    $display("commit seen in the flush cycle");
                    other_errors++;
                end
                if (exp_pc.size() == 0) begin
                    $display("exception seen with no instruction pending");
                    other_errors++;
                end else begin
                    assert (exp_ill[0]) else begin
                        $display("exception raised while a legal instruction was oldest");
                        other_errors++;
                    end
                    assert (exception_pc == exp_pc[0]) else begin
                        $display("mismatch exception_pc expected %h actual %h",
                                 exp_pc[0], exception_pc);
                        mismatches++;
                    end
                    flushed += exp_pc.size();       // Trapping op and all younger ones
                    exp_pc.delete();
                    exp_dest.delete();
                    exp_val.delete();
                    exp_ill.delete();
                end
                exceptions++;
            end
            if (in_valid && in_ready) begin
                exp_pc.push_back(in_pc);
                exp_dest.push_back(in_dest);
                exp_val.push_back(expected_result(in_op, in_a, in_b));
                exp_ill.push_back(in_op == rob_pkg::OP_ILLEGAL);
                accepts++;
            end
            if (in_valid && !in_ready) saw_stall = 1'b1;
        end
    end

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds the instruction at the input until it is taken
    task automatic send_instr(input rob_pkg::opcode_e op, input rob_pkg::xlen_t a,
                              input rob_pkg::xlen_t b);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_pc    = next_pc;
        in_op    = op;
        in_dest  = rob_pkg::reg_idx_t'($random(seed));
        in_a     = a;
        in_b     = b;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            taken = in_ready;
            waited++;
            #1;
        end
        if (!taken) begin
            $display("instruction at pc %h was never accepted", next_pc);
            timeouts++;
        end
        in_valid = 1'b0;
        next_pc  = next_pc + 32'd4;
    endtask

    task automatic send_random_stream(input int n);
        rob_pkg::opcode_e op;
        for (int i = 0; i < n; i++) begin
            op = rob_pkg::opcode_e'($unsigned($random(seed)) % 3);     // ADD, SUB or XOR
            send_instr(op, rob_pkg::xlen_t'($random(seed)), rob_pkg::xlen_t'($random(seed)));
            if ($unsigned($random(seed)) % 4 == 0) idle_cycles(1);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pc.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_pc.size() != 0) begin
            $display("%0d instructions never committed", exp_pc.size());
            timeouts++;
        end
        idle_cycles(3);
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready stayed low after reset");
            timeouts++;
        end
    endtask

    initial begin
        int a0;
        int c0;
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_pc    = '0;
        in_op    = rob_pkg::OP_ADD;
        in_dest  = '0;
        in_a     = '0;
        in_b     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_ready();

        send_random_stream(40);                     // In-order commit of simple ops
        wait_drain();

        send_instr(rob_pkg::OP_MUL, rob_pkg::xlen_t'($random(seed)),
                   rob_pkg::xlen_t'($random(seed)));
        repeat (4) send_instr(rob_pkg::OP_ADD, rob_pkg::xlen_t'($random(seed)),
                              rob_pkg::xlen_t'($random(seed)));
        wait_drain();

        a0        = accepts;                        // Multiply burst
        c0        = commits;
        saw_stall = 1'b0;
        repeat (30) send_instr(rob_pkg::OP_MUL, rob_pkg::xlen_t'($random(seed)),
                               rob_pkg::xlen_t'($random(seed)));
        wait_drain();
        assert (saw_stall) else begin
            $display("in_ready never dropped during the multiply burst");
            other_errors++;
        end
        assert (accepts - a0 == commits - c0) else begin
            $display("accepted and committed counts differ after the burst");
            other_errors++;
        end

        send_random_stream(6);                      // Trap in the middle of a stream
        send_instr(rob_pkg::OP_ILLEGAL, rob_pkg::xlen_t'($random(seed)),
                   rob_pkg::xlen_t'($random(seed)));
        send_random_stream(6);
        wait_drain();
        send_random_stream(20);
        wait_drain();

        assert (exceptions == 1) else begin
            $display("expected one exception pulse but saw %0d", exceptions);
            other_errors++;
        end
        assert (accepts == commits + flushed) else begin
            $display("instructions lost or duplicated between input and commit");
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/rob_pkg.sv
source/op_dispatcher.sv
source/exec_lane.sv
source/reorder_buffer.sv
source/ooo_backend.sv
tb/ooo_backend_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= ooo_backend_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
